// File: all.f
logic/long_pkg.sv
logic/long_op_decoder.sv
logic/long_hazard_unit.sv
logic/mul_unit.sv
logic/div_unit.sv
logic/commit_arbiter.sv
logic/long_exec_top.sv
verif/tb_long_exec.sv

// File: verif/tb_long_exec.sv
// directed testbench for the rv32m long instruction back end
// reference model, hazard model, lfsr stimulus, commit monitor
`timescale 1ns/1ps

module tb_long_exec;
    import long_pkg::*;

    localparam int MUL_LAT     = 4;   // negedge cycles from accept to commit seen
    localparam int DIV_LAT     = 34;
    localparam int ISSUE_LIMIT = 200;
    localparam int DRAIN_LIMIT = 400;

    logic         clk;
    logic         rst_n;
    logic         inst_valid_i;
    logic [31:0]  inst_i;
    logic [31:0]  rs1_data_i;
    logic [31:0]  rs2_data_i;
    logic         stall_o;
    logic         lock_o;
    logic         commit_valid_o;
    long_commit_t commit_o;

    // expected table, one entry per commit id
    bit           exp_vld   [NUM_SLOTS];
    bit           exp_div   [NUM_SLOTS];
    bit           exp_exact [NUM_SLOTS];
    long_commit_t exp_res   [NUM_SLOTS];
    int           exp_cyc   [NUM_SLOTS];
    int           exp_lat   [NUM_SLOTS];
    int           exp_seq   [NUM_SLOTS];
    int           last_seq  [32];       // per rd, for in-order writes

    int           cyc;
    int           seq;
    int           errs;
    int           checks;
    int           tests;
    int           commit_cnt;
    int           last_commit_cyc;
    int           last_issue_id;
    bit           relax_div_lat;        // div may lose to mul in mixed runs
    logic [31:0]  lfsr_q;

    logic [31:0] mul_a [8] = '{32'h0, 32'h1, 32'h8000_0000, 32'h8000_0000,
                               32'h7fff_ffff, 32'hffff_ffff, 32'h1234_5678, 32'h7fff_ffff};
    logic [31:0] mul_b [8] = '{32'h0, 32'hffff_ffff, 32'h8000_0000, 32'hffff_ffff,
                               32'h7fff_ffff, 32'hffff_ffff, 32'h9abc_def0, 32'h8000_0000};
    logic [31:0] div_a [10] = '{32'd100, 32'hffff_ff9c, 32'd100, 32'hffff_ff9c, 32'd5,
                                32'h8000_0000, 32'h8000_0000, 32'hffff_ffff,
                                32'hffff_ffff, 32'd7};
    logic [31:0] div_b [10] = '{32'd7, 32'd7, 32'hffff_fff9, 32'hffff_fff9, 32'd0,
                                32'hffff_ffff, 32'd1, 32'd0, 32'd2, 32'd100};

    long_exec_top i_long_exec_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .inst_valid_i   (inst_valid_i),
        .inst_i         (inst_i),
        .rs1_data_i     (rs1_data_i),
        .rs2_data_i     (rs2_data_i),
        .stall_o        (stall_o),
        .lock_o         (lock_o),
        .commit_valid_o (commit_valid_o),
        .commit_o       (commit_o)
    );

    always #4 clk = ~clk;  // 8 ns period

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v      = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'ha300_0000) : (lfsr_q >> 1);
        end
        return v;
    endfunction

    // r-type word, opcode OP with the m extension funct7
    function automatic logic [31:0] encode(input m_op_e op, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2);
        return {7'b0000001, rs2, rs1, op, rd, 7'b0110011};
    endfunction

    // riscv m semantics, 64 bit products and int division
    function automatic logic [31:0] ref_result(input m_op_e op, input logic [31:0] a,
                                               input logic [31:0] b);
        logic signed [63:0] ps;
        logic [63:0]        pu;
        int                 sa;
        int                 sb;
        sa = a;
        sb = b;
        case (op)
            MUL: begin
                pu = {32'd0, a} * {32'd0, b};
                return pu[31:0];
            end
            MULH: begin
                ps = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
                return ps[63:32];
            end
            MULHSU: begin
                ps = $signed({{32{a[31]}}, a}) * $signed({32'd0, b}); // b taken unsigned
                return ps[63:32];
            end
            MULHU: begin
                pu = {32'd0, a} * {32'd0, b};
                return pu[63:32];
            end
            DIV: begin
                if (b == 0) return 32'hffff_ffff;
                if (a == 32'h8000_0000 && b == 32'hffff_ffff) return a; // overflow
                return sa / sb;
            end
            DIVU: return (b == 0) ? 32'hffff_ffff : a / b;
            REM: begin
                if (b == 0) return a;
                if (a == 32'h8000_0000 && b == 32'hffff_ffff) return 32'h0;
                return sa % sb;
            end
            default: return (b == 0) ? a : a % b;  // remu
        endcase
    endfunction

    // stall rules against the expected table
    function automatic bit model_stall(input m_op_e op, input logic [4:0] rd,
                                       input logic [4:0] rs1, input logic [4:0] rs2);
        bit full;
        bit hit;
        bit is_div;
        full   = 1'b1;
        hit    = 1'b0;
        is_div = op[2];
        for (int s = 0; s < NUM_SLOTS; s++) begin
            if (exp_vld[s]) begin
                if (exp_res[s].rd == rs1 || exp_res[s].rd == rs2) hit = 1'b1; // raw
                if (rd != 0 && exp_res[s].rd == rd && exp_div[s] != is_div) hit = 1'b1;
                if (exp_div[s] && is_div) hit = 1'b1;  // one divider
            end else begin
                full = 1'b0;
            end
        end
        return hit || full;
    endfunction

    function automatic int free_slot();
        for (int s = 0; s < NUM_SLOTS; s++) begin
            if (!exp_vld[s]) return s;
        end
        return -1;
    endfunction

    // entries still waiting for their commit
    function automatic int outstanding();
        int n;
        n = 0;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            if (exp_vld[s]) n++;
        end
        return n;
    endfunction

    task automatic check_commit(input long_commit_t got, input long_commit_t exp,
                                input string what);
        checks++;
        if (got !== exp) begin
            errs++;
            $display("ERR %0t: %s got id %0d rd %0d data %08h, expected id %0d rd %0d data %08h",
                     $time, what, got.id, got.rd, got.data, exp.id, exp.rd, exp.data);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errs++;
            $display("ERR %0t: %s got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_int(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            errs++;
            $display("ERR %0t: %s got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("timeout: no progress while %s at time %0t", what, $time);
        $display("STATUS: FAIL");
        $finish;
    endtask

    task automatic report_test(input string name, input int start);
        tests++;
        if (errs == start) $display("test %-10s ok", name);
        else $display("test %-10s %0d errors", name, errs - start);
    endtask

    // every commit matched by id against the expected table
    always @(negedge clk) begin : commit_monitor
        int cid;
        int lat;
        if (rst_n && commit_valid_o) begin
            cid = commit_o.id;
            if (!exp_vld[cid]) begin
                errs++;
                $display("unexpected commit on id %0d at %0t, nothing outstanding there",
                         cid, $time);
            end else begin
                check_commit(commit_o, exp_res[cid], "commit");
                lat = cyc - exp_cyc[cid];
                if (exp_exact[cid] || lat < exp_lat[cid]) begin
                    check_int(lat, exp_lat[cid], "commit latency");
                end
                check_bit(exp_seq[cid] > last_seq[exp_res[cid].rd], 1'b1, "same rd order");
                last_seq[exp_res[cid].rd] = exp_seq[cid];
                exp_vld[cid] = 1'b0;
            end
            commit_cnt++;
            last_commit_cyc = cyc;
        end
    end

    // enters and leaves on a falling edge, stall checked every cycle
    task automatic issue_op(input m_op_e op, input logic [4:0] rd, input logic [4:0] rs1,
                            input logic [4:0] rs2, input logic [31:0] a,
                            input logic [31:0] b, output int stalls, output int acc_cyc);
        int id;
        bit accepted;
        stalls   = 0;
        accepted = 1'b0;
        inst_i       = encode(op, rd, rs1, rs2);
        rs1_data_i   = a;
        rs2_data_i   = b;
        inst_valid_i = 1'b1;
        while (!accepted) begin
            #2;  // monitor has retired this cycle's commit
            check_bit(stall_o, model_stall(op, rd, rs1, rs2), "stall_o");
            if (!stall_o) begin
                accepted = 1'b1;
            end else begin
                if (stalls == ISSUE_LIMIT) fail_timeout("waiting for issue");
                stalls++;
                @(negedge clk);
            end
        end
        id      = free_slot();  // lowest free slot
        acc_cyc = cyc;
        if (id < 0) begin
            errs++;
            $display("instruction accepted at %0t with all four slots in use", $time);
        end else begin
            exp_vld[id]   = 1'b1;
            exp_div[id]   = op[2];
            exp_res[id]   = '{id: 2'(id), rd: rd, data: ref_result(op, a, b)};
            exp_cyc[id]   = cyc;
            exp_lat[id]   = op[2] ? DIV_LAT : MUL_LAT;
            exp_exact[id] = !op[2] || !relax_div_lat;
            exp_seq[id]   = seq;
            seq++;
        end
        last_issue_id = id;
        @(negedge clk);
        inst_valid_i = 1'b0;
    endtask

    // lock must stay up while anything is outstanding, drop after
    task automatic wait_drain();
        int n;
        n = 0;
        #2;
        while (outstanding() != 0) begin
            check_bit(lock_o, 1'b1, "lock_o while outstanding");
            if (n == DRAIN_LIMIT) fail_timeout("waiting for outstanding commits");
            n++;
            @(negedge clk);
            #2;
        end
        @(negedge clk);
        check_bit(lock_o, 1'b0, "lock_o after last commit");
        check_bit(stall_o, 1'b0, "stall_o when idle");
    endtask

    task automatic test_idle();
        int start;
        start = errs;
        check_bit(stall_o, 1'b0, "stall_o after reset");
        check_bit(lock_o, 1'b0, "lock_o after reset");
        check_bit(commit_valid_o, 1'b0, "commit_valid_o after reset");
        inst_i       = {7'b0, 5'd2, 5'd1, 3'b000, 5'd3, 7'b0110011}; // plain add
        inst_valid_i = 1'b1;
        #2;
        check_bit(stall_o, 1'b0, "stall_o on add");
        @(negedge clk);
        inst_valid_i = 1'b0;
        check_bit(lock_o, 1'b0, "lock_o after add");
        report_test("idle", start);
    endtask

    task automatic test_mul();
        int start;
        int st;
        int acc;
        int k;
        start = errs;
        k     = 0;
        for (int o = 0; o < 4; o++) begin
            for (int i = 0; i < 8; i++) begin
                issue_op(m_op_e'(o), 5'(1 + k % 15), 5'(16 + i), 5'(24 + i),
                         mul_a[i], mul_b[i], st, acc);
                k++;
            end
        end
        wait_drain();
        report_test("mul", start);
    endtask

    task automatic test_div();
        int start;
        int st;
        int acc;
        int k;
        start = errs;
        k     = 0;
        for (int o = 4; o < 8; o++) begin
            for (int i = 0; i < 10; i++) begin
                issue_op(m_op_e'(o), 5'(1 + k % 15), 5'(16 + i), 5'(26 + i % 4),
                         div_a[i], div_b[i], st, acc);
                k++;
            end
        end
        wait_drain();
        report_test("div", start);
    endtask

    task automatic test_raw();
        int start;
        int st;
        int acc;
        start = errs;
        issue_op(DIV, 5'd5, 5'd1, 5'd2, 32'd1000, 32'd9, st, acc);
        inst_i       = encode(DIVU, 5'd6, 5'd3, 5'd4);  // second divide, unit busy
        inst_valid_i = 1'b1;
        #2;
        check_bit(stall_o, 1'b1, "stall_o on divide while busy");
        @(negedge clk);
        inst_valid_i = 1'b0;
        issue_op(MUL, 5'd8, 5'd5, 5'd3, 32'd77, 32'd3, st, acc); // reads x5
        check_bit(st > 0, 1'b1, "raw stall seen");
        check_int(acc, last_commit_cyc, "raw release cycle");
        wait_drain();
        report_test("raw", start);
    endtask

    task automatic test_waw();
        int start;
        int st;
        int st2;
        int acc;
        start = errs;
        issue_op(DIVU, 5'd7, 5'd1, 5'd2, 32'h1234_5678, 32'd3, st, acc);
        issue_op(MUL, 5'd7, 5'd3, 5'd4, 32'd6, 32'd7, st, acc);  // cross unit waw
        check_bit(st > 0, 1'b1, "waw stall seen");
        check_int(acc, last_commit_cyc, "waw release cycle");
        issue_op(MULHU, 5'd9, 5'd3, 5'd4, 32'hdead_beef, 32'h0bad_f00d, st, acc);
        issue_op(MUL, 5'd9, 5'd3, 5'd4, 32'd11, 32'd13, st2, acc);
        check_int(st + st2, 0, "same unit waw stalls");
        wait_drain();
        report_test("waw", start);
    endtask

    task automatic test_lock();
        int start;
        int st;
        int acc;
        start = errs;
        check_bit(lock_o, 1'b0, "lock_o before first issue");
        issue_op(DIV, 5'd10, 5'd1, 5'd2, 32'd50, 32'd5, st, acc);
        check_bit(lock_o, 1'b1, "lock_o after first accept");
        check_int(last_issue_id, 0, "first id");
        issue_op(MUL, 5'd11, 5'd1, 5'd2, 32'd2, 32'd3, st, acc);
        issue_op(MUL, 5'd12, 5'd1, 5'd2, 32'd4, 32'd5, st, acc);
        issue_op(MUL, 5'd13, 5'd1, 5'd2, 32'd6, 32'd7, st, acc);
        issue_op(MUL, 5'd14, 5'd1, 5'd2, 32'd8, 32'd9, st, acc); // table full
        check_bit(st > 0, 1'b1, "full stall seen");
        check_int(last_issue_id, 1, "id after full");
        wait_drain();
        report_test("lock", start);
    endtask

    task automatic test_random();
        int          start;
        int          st;
        int          acc;
        int          base;
        m_op_e       op;
        logic [31:0] a;
        logic [31:0] b;
        start         = errs;
        base          = commit_cnt;
        relax_div_lat = 1'b1;
        for (int i = 0; i < 40; i++) begin
            op = m_op_e'(rand_bits(3));
            a  = rand_bits(32);
            b  = rand_bits(32);
            if (rand_bits(3) == 0) b = '0;  // some divide by zero
            issue_op(op, 5'(1 + i % 15), 5'(16 + i % 16), 5'(16 + (i + 5) % 16), a, b,
                     st, acc);
        end
        wait_drain();
        relax_div_lat = 1'b0;
        check_int(commit_cnt - base, 40, "random commit count");
        report_test("random", start);
    endtask

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        inst_valid_i  = 1'b0;
        inst_i        = '0;
        rs1_data_i    = '0;
        rs2_data_i    = '0;
        cyc           = 0;
        seq           = 0;
        errs          = 0;
        checks        = 0;
        tests         = 0;
        commit_cnt    = 0;
        relax_div_lat = 1'b0;
        lfsr_q        = 32'hed4a_f22d;
        for (int s = 0; s < NUM_SLOTS; s++) exp_vld[s] = 1'b0;
        for (int r = 0; r < 32; r++) last_seq[r] = -1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_idle();
        test_mul();
        test_div();
        test_raw();
        test_waw();
        test_lock();
        test_random();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errs);
        if (errs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: logic/long_exec_top.sv
// long instruction back end top level
// decoder, scoreboard, mul and div units, commit arbiter
`timescale 1ns/1ps

module long_exec_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      inst_valid_i,
    input  logic [31:0]               inst_i,
    input  logic [long_pkg::XLEN-1:0] rs1_data_i,
    input  logic [long_pkg::XLEN-1:0] rs2_data_i,
    output logic                      stall_o,
    output logic                      lock_o,
    output logic                      commit_valid_o,
    output long_pkg::long_commit_t    commit_o
);
    import long_pkg::*;

    dec_info_t              dec;
    logic                   issue;
    logic [COMMIT_ID_W-1:0] issue_id;
    long_issue_t            issue_req;
    logic                   mul_start;
    logic                   div_start;
    logic                   mul_done;
    logic                   div_done;
    logic                   div_busy;
    logic                   div_grant;
    long_commit_t           mul_res;
    long_commit_t           div_res;

    // work item, operands come straight from the ports
    assign issue_req = '{id: issue_id, rd: dec.rd, op: dec.op,
                         a: rs1_data_i, b: rs2_data_i};
    assign mul_start = issue && (dec.exu == EXU_MUL);
    assign div_start = issue && (dec.exu == EXU_DIV);

    long_op_decoder i_long_op_decoder (
        .inst_i (inst_i),
        .dec_o  (dec)
    );

    long_hazard_unit i_long_hazard_unit (
        .clk            (clk),
        .rst_n          (rst_n),
        .inst_valid_i   (inst_valid_i),
        .dec_i          (dec),
        .div_busy_i     (div_busy),
        .commit_valid_i (commit_valid_o),  // frees the slot on the same edge
        .commit_id_i    (commit_o.id),
        .stall_o        (stall_o),
        .issue_o        (issue),
        .issue_id_o     (issue_id),
        .lock_o         (lock_o)
    );

    mul_unit i_mul_unit (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (mul_start),
        .req_i   (issue_req),
        .done_o  (mul_done),
        .res_o   (mul_res)
    );

    div_unit i_div_unit (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (div_start),
        .req_i   (issue_req),
        .grant_i (div_grant),
        .busy_o  (div_busy),
        .done_o  (div_done),
        .res_o   (div_res)
    );

    commit_arbiter i_commit_arbiter (
        .clk            (clk),
        .rst_n          (rst_n),
        .mul_done_i     (mul_done),
        .mul_res_i      (mul_res),
        .div_done_i     (div_done),
        .div_res_i      (div_res),
        .div_grant_o    (div_grant),
        .commit_valid_o (commit_valid_o),
        .commit_o       (commit_o)
    );

endmodule

// File: logic/commit_arbiter.sv
// merges multiplier and divider results into one commit per cycle
// multiplier has priority, divider waits on grant
`timescale 1ns/1ps

module commit_arbiter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   mul_done_i,
    input  long_pkg::long_commit_t mul_res_i,
    input  logic                   div_done_i,
    input  long_pkg::long_commit_t div_res_i,
    output logic                   div_grant_o,
    output logic                   commit_valid_o,
    output long_pkg::long_commit_t commit_o
);
    import long_pkg::*;

    logic         valid_q;
    long_commit_t commit_q;

    // mul pipe cannot stall, so it always wins a collision
    assign div_grant_o = div_done_i && !mul_done_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= mul_done_i || div_grant_o; // single cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        if (mul_done_i) begin
            commit_q <= mul_res_i;
        end else if (div_grant_o) begin
            commit_q <= div_res_i;
        end
    end

    assign commit_valid_o = valid_q;
    assign commit_o       = commit_q;

    // an id retires once; divider hold must not repeat it
    a_one_commit_per_id: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid_o |=> !(commit_valid_o && (commit_o.id == $past(commit_o.id))))
        else $error("id %0d committed twice in a row", commit_o.id);

endmodule

// File: logic/div_unit.sv
// radix-2 restoring divider for div/divu/rem/remu
// magnitude core with sign fix-up, result held until granted
`timescale 1ns/1ps

module div_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start_i,
    input  long_pkg::long_issue_t  req_i,
    input  logic                   grant_i,
    output logic                   busy_o,
    output logic                   done_o,
    output long_pkg::long_commit_t res_o
);
    import long_pkg::*;

    typedef enum logic [1:0] {D_IDLE, D_RUN, D_DONE} div_st_e;

    typedef struct packed {
        logic [COMMIT_ID_W-1:0] id;
        logic [REG_ADDR_W-1:0]  rd;
        logic                   is_rem;
        logic                   div_zero;
        logic                   neg_q;
        logic                   neg_r;   // remainder follows dividend sign
    } div_ctx_t;

    div_st_e              st_q;
    logic [DIV_CNT_W-1:0] cnt_q;
    div_ctx_t             ctx_q;
    logic [XLEN-1:0]      quo_q;  // dividend shifts out, quotient shifts in
    logic [XLEN-1:0]      rem_q;
    logic [XLEN-1:0]      dvs_q;
    logic                 is_signed;
    logic                 a_neg;
    logic                 b_neg;
    logic [XLEN:0]        rem_sh;
    logic [XLEN:0]        diff;
    logic [XLEN-1:0]      q_fix;
    logic [XLEN-1:0]      r_fix;

    assign is_signed = (req_i.op == DIV) || (req_i.op == REM);
    assign a_neg     = is_signed && req_i.a[XLEN-1];
    assign b_neg     = is_signed && req_i.b[XLEN-1];

    assign rem_sh = {rem_q, quo_q[XLEN-1]};
    assign diff   = rem_sh - {1'b0, dvs_q};    // msb set means no subtract

    // /0 gives all ones; min/-1 falls out of the magnitude path as min, rem 0
    assign q_fix = ctx_q.div_zero ? '1 : (ctx_q.neg_q ? -quo_q : quo_q);
    assign r_fix = ctx_q.neg_r ? -rem_q : rem_q; // /0 gives back the dividend

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st_q  <= D_IDLE;
            cnt_q <= '0;
        end else begin
            case (st_q)
                D_IDLE: if (start_i) begin
                    st_q  <= D_RUN;
                    cnt_q <= '0;
                end
                D_RUN: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == DIV_CNT_W'(DIV_CYCLES - 1)) begin
                        st_q <= D_DONE;
                    end
                end
                default: if (grant_i) st_q <= D_IDLE; // wait for the arbiter
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (st_q == D_IDLE && start_i) begin
            ctx_q <= '{id: req_i.id, rd: req_i.rd, is_rem: req_i.op[1],
                       div_zero: (req_i.b == '0), neg_q: a_neg ^ b_neg, neg_r: a_neg};
            quo_q <= a_neg ? -req_i.a : req_i.a;
            dvs_q <= b_neg ? -req_i.b : req_i.b;
            rem_q <= '0;
        end else if (st_q == D_RUN) begin
            rem_q <= diff[XLEN] ? rem_sh[XLEN-1:0] : diff[XLEN-1:0];
            quo_q <= {quo_q[XLEN-2:0], !diff[XLEN]};
        end
    end

    assign busy_o = (st_q != D_IDLE); // stays high through D_DONE
    assign done_o = (st_q == D_DONE);
    // quotient and remainder sit still in D_DONE
    assign res_o  = '{id: ctx_q.id, rd: ctx_q.rd, data: ctx_q.is_rem ? r_fix : q_fix};

    // scoreboard must hold off a second divide
    a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
        start_i |-> !busy_o)
        else $error("divide started while divider busy");

endmodule

// File: logic/mul_unit.sv
// three stage 32x32 multiplier for mul/mulh/mulhsu/mulhu
// id and rd ride along, one new op per cycle
`timescale 1ns/1ps

module mul_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start_i,
    input  long_pkg::long_issue_t  req_i,
    output logic                   done_o,
    output long_pkg::long_commit_t res_o
);
    import long_pkg::*;

    typedef struct packed {
        logic [COMMIT_ID_W-1:0] id;
        logic [REG_ADDR_W-1:0]  rd;
        logic                   hi;  // upper word wanted
        logic [XLEN:0]          a;   // 33 bit, sign or zero extended
        logic [XLEN:0]          b;
    } mul_s1_t;

    typedef struct packed {
        logic [COMMIT_ID_W-1:0] id;
        logic [REG_ADDR_W-1:0]  rd;
        logic                   hi;
        logic [2*XLEN-1:0]      prod;
    } mul_s2_t;

    logic [2:0]               vld_q;     // one valid bit per stage
    mul_s1_t                  s1_q;
    mul_s2_t                  s2_q;
    long_commit_t             s3_q;
    logic                     a_sgn;
    logic                     b_sgn;
    logic signed [2*XLEN+1:0] prod_full;

    assign a_sgn = (req_i.op == MULH) || (req_i.op == MULHSU);
    assign b_sgn = (req_i.op == MULH);  // mulhsu: rs2 unsigned

    // 33x33 signed covers every signedness mix
    assign prod_full = $signed(s1_q.a) * $signed(s1_q.b);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[1:0], start_i}; // no back pressure, pipe always moves
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin                  // stage 1: operand extension
            s1_q.id <= req_i.id;
            s1_q.rd <= req_i.rd;
            s1_q.hi <= (req_i.op != MUL);
            s1_q.a  <= {a_sgn & req_i.a[XLEN-1], req_i.a};
            s1_q.b  <= {b_sgn & req_i.b[XLEN-1], req_i.b};
        end
        if (vld_q[0]) begin                 // stage 2: full product
            s2_q.id   <= s1_q.id;
            s2_q.rd   <= s1_q.rd;
            s2_q.hi   <= s1_q.hi;
            s2_q.prod <= prod_full[2*XLEN-1:0];
        end
        if (vld_q[1]) begin                 // stage 3: word select
            s3_q.id   <= s2_q.id;
            s3_q.rd   <= s2_q.rd;
            s3_q.data <= s2_q.hi ? s2_q.prod[2*XLEN-1:XLEN] : s2_q.prod[XLEN-1:0];
        end
    end

    assign done_o = vld_q[2];
    assign res_o  = s3_q;

endmodule

// File: logic/long_hazard_unit.sv
// scoreboard for outstanding long instructions
// commit id allocation, raw/waw/full/div-busy stall, lock flag
`timescale 1ns/1ps

module long_hazard_unit (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             inst_valid_i,
    input  long_pkg::dec_info_t              dec_i,
    input  logic                             div_busy_i,
    input  logic                             commit_valid_i,
    input  logic [long_pkg::COMMIT_ID_W-1:0] commit_id_i,
    output logic                             stall_o,
    output logic                             issue_o,
    output logic [long_pkg::COMMIT_ID_W-1:0] issue_id_o,
    output logic                             lock_o
);
    import long_pkg::*;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;
        exu_e                  exu;
    } slot_t;

    logic [NUM_SLOTS-1:0] slot_vld_q;
    slot_t                slot_q [NUM_SLOTS];
    logic [NUM_SLOTS-1:0] live;      // valid and not retiring this cycle
    logic [NUM_SLOTS-1:0] raw_vec;
    logic [NUM_SLOTS-1:0] waw_vec;
    logic                 full;
    logic                 div_struct;
    logic                 req;

    // all slots compared in parallel
    always_comb begin
        for (int s = 0; s < NUM_SLOTS; s++) begin
            live[s] = slot_vld_q[s] &&
                      !(commit_valid_i && (commit_id_i == COMMIT_ID_W'(s)));
            raw_vec[s] = live[s] &&
                         ((dec_i.rs1_re && (dec_i.rs1 == slot_q[s].rd)) ||
                          (dec_i.rs2_re && (dec_i.rs2 == slot_q[s].rd)));
            // same unit keeps write order by itself, only cross-unit waw stalls
            waw_vec[s] = live[s] && dec_i.rd_we && (dec_i.rd == slot_q[s].rd) &&
                         (dec_i.exu != slot_q[s].exu);
        end
    end

    assign full       = &live;
    assign div_struct = div_busy_i && (dec_i.exu == EXU_DIV); // single divider
    assign req        = inst_valid_i && dec_i.is_long;

    assign stall_o = req && ((|raw_vec) || (|waw_vec) || full || div_struct);
    assign issue_o = req && !stall_o;

    // lowest free slot wins, scan from the top down
    always_comb begin
        issue_id_o = '0;
        for (int s = NUM_SLOTS - 1; s >= 0; s--) begin
            if (!live[s]) begin
                issue_id_o = COMMIT_ID_W'(s);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_vld_q <= '0;
        end else begin
            if (commit_valid_i) begin
                slot_vld_q[commit_id_i] <= 1'b0;
            end
            // set after clear, a slot can retire and refill on one edge
            if (issue_o) begin
                slot_vld_q[issue_id_o] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue_o) begin
            slot_q[issue_id_o] <= '{rd: dec_i.rd, exu: dec_i.exu};
        end
    end

    assign lock_o = |slot_vld_q; // any long op still in flight

    // results only come back for ids handed out earlier
    a_commit_hits_valid: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid_i |-> slot_vld_q[commit_id_i])
        else $error("commit on empty slot %0d", commit_id_i);

    // a running divide always owns an entry
    a_div_busy_locked: assert property (@(posedge clk) disable iff (!rst_n)
        div_busy_i |-> lock_o)
        else $error("divider busy with no entry outstanding");

endmodule

// File: logic/long_op_decoder.sv
// rv32m instruction decoder
// picks out mul/div words and their register fields
`timescale 1ns/1ps

module long_op_decoder (
    input  logic [31:0]         inst_i,
    output long_pkg::dec_info_t dec_o
);
    import long_pkg::*;

    logic [6:0]            opcode;
    logic [6:0]            funct7;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic                  is_long;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign rd     = inst_i[11:7];

    // only OP with funct7 0000001 goes to the long units
    assign is_long = (opcode == OPC_OP) && (funct7 == FUNCT7_MULDIV);

    always_comb begin
        dec_o         = '0;
        dec_o.is_long = is_long;
        dec_o.op      = m_op_e'(funct3);              // funct3 maps straight onto the op
        dec_o.exu     = funct3[2] ? EXU_DIV : EXU_MUL; // upper half is div/rem
        dec_o.rd      = rd;
        dec_o.rs1     = inst_i[19:15];
        dec_o.rs2     = inst_i[24:20];
        // x0 writes are dropped, no scoreboard write port needed
        dec_o.rd_we   = is_long && (rd != '0);
        // r-type, both sources always read
        dec_o.rs1_re  = is_long;
        dec_o.rs2_re  = is_long;
    end

endmodule

// File: logic/long_pkg.sv
// shared widths and opcode constants for the rv32m back end
// execution unit and funct3 enumerations
// issue, commit and decode structs
package long_pkg;

    localparam int REG_ADDR_W  = 5;
    localparam int XLEN        = 32;
    localparam int COMMIT_ID_W = 2;
    localparam int NUM_SLOTS   = 4;                  // one slot per commit id
    localparam int DIV_CYCLES  = 32;                 // one quotient bit per cycle
    localparam int DIV_CNT_W   = $clog2(DIV_CYCLES);

    localparam logic [6:0] OPC_OP        = 7'b0110011; // r-type alu major opcode
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001; // m extension marker

    typedef enum logic {
        EXU_MUL = 1'b0,
        EXU_DIV = 1'b1
    } exu_e;

    // funct3 encodings of rv32m
    typedef enum logic [2:0] {
        MUL    = 3'b000,
        MULH   = 3'b001,
        MULHSU = 3'b010,
        MULHU  = 3'b011,
        DIV    = 3'b100,
        DIVU   = 3'b101,
        REM    = 3'b110,
        REMU   = 3'b111
    } m_op_e;

    typedef struct packed {
        logic [COMMIT_ID_W-1:0] id;
        logic [REG_ADDR_W-1:0]  rd;
        m_op_e                  op;
        logic [XLEN-1:0]        a;   // rs1 value
        logic [XLEN-1:0]        b;   // rs2 value
    } long_issue_t;

    typedef struct packed {
        logic [COMMIT_ID_W-1:0] id;
        logic [REG_ADDR_W-1:0]  rd;
        logic [XLEN-1:0]        data;
    } long_commit_t;

    typedef struct packed {
        logic                  is_long;
        exu_e                  exu;
        m_op_e                 op;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic                  rd_we;
        logic                  rs1_re;
        logic                  rs2_re;
    } dec_info_t;

endpackage
